// ==== canDelay_pkg.sv ====
package canDelay_pkg;

    // CAN standard frame constants
    parameter int ID_BITS = 11;
    parameter int IDLE_BITS = 11;
    parameter int STUFF_LIMIT = 5;

    // Signal memory geometry
    parameter int WORD_BITS = 32;
    parameter int ADDR_BITS = 16;

    // Recovered bus bit with its sample strobe
    typedef struct packed {
        logic value;
        logic strobe;
    } canBit_t;

    // Identifier compare result
    typedef struct packed {
        logic valid;
        logic match;
    } idDecision_t;

    // One stored signal in word units
    typedef struct packed {
        logic [ADDR_BITS-1:0] base;
        logic [ADDR_BITS-1:0] numWords;
    } sigRegion_t;

    // Wishbone master side
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [ADDR_BITS-1:0] adr;
    } wbReq_t;

    // Wishbone slave side
    typedef struct packed {
        logic                 ack;
        logic [WORD_BITS-1:0] dat;
    } wbRsp_t;

    // FIFO entry, last marks the final word of a signal
    typedef struct packed {
        logic                 last;
        logic [WORD_BITS-1:0] data;
    } sigWord_t;

endpackage

// ==== canSampler.sv ====
module canSampler
    import canDelay_pkg::*;
#(
    parameter int CLKS_PER_BIT = 20
) (
    input  logic    clk,
    input  logic    resetN,
    input  logic    i_canRx,
    output canBit_t o_bit
);

    localparam int CNT_BITS = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_BITS-1:0] SAMPLE_FIRST = CNT_BITS'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_BITS-1:0] SAMPLE_MID = CNT_BITS'(CLKS_PER_BIT / 2);
    localparam logic [CNT_BITS-1:0] SAMPLE_LAST = CNT_BITS'(CLKS_PER_BIT / 2 + 1);
    localparam logic [CNT_BITS-1:0] COUNT_LAST = CNT_BITS'(CLKS_PER_BIT - 1);

    logic                rxMeta;
    logic                rxSync;
    logic                rxPrev;
    logic                fallingEdge;
    logic [CNT_BITS-1:0] bitCnt;
    logic [1:0]          samples;
    logic                vote;

    // Two-stage synchronizer, line idles recessive
    always_ff @(posedge clk) begin
        if (!resetN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= i_canRx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    assign fallingEdge = rxPrev & ~rxSync;

    // Bit timer with hard sync on recessive to dominant
    always_ff @(posedge clk) begin
        if (!resetN) begin
            bitCnt <= '0;
        end else if (fallingEdge) begin
            bitCnt <= '0;
        end else if (bitCnt == COUNT_LAST) begin
            bitCnt <= '0;
        end else begin
            bitCnt <= bitCnt + 1'b1;
        end
    end

    // First two samples, the third is taken live
    always_ff @(posedge clk) begin
        if (bitCnt == SAMPLE_FIRST || bitCnt == SAMPLE_MID) begin
            samples <= {samples[0], rxSync};
        end
    end

    assign vote = (samples[1] & samples[0]) | (samples[1] & rxSync) | (samples[0] & rxSync);

    always_ff @(posedge clk) begin
        if (!resetN) begin
            o_bit.value <= 1'b1;
            o_bit.strobe <= 1'b0;
        end else begin
            o_bit.strobe <= (bitCnt == SAMPLE_LAST);
            if (bitCnt == SAMPLE_LAST) begin
                o_bit.value <= vote;
            end
        end
    end

    // One strobe per bit time, never back to back
    assert property (@(posedge clk) disable iff (!resetN)
        o_bit.strobe |=> !o_bit.strobe);

endmodule

// ==== frameMonitor.sv ====
module frameMonitor
    import canDelay_pkg::*;
(
    input  logic               clk,
    input  logic               resetN,
    input  canBit_t            i_bit,
    input  logic [ID_BITS-1:0] i_canId,
    output idDecision_t        o_decision
);

    localparam int IDLE_CNT_BITS = $clog2(IDLE_BITS + 1);
    localparam int RUN_BITS = $clog2(STUFF_LIMIT + 1);
    localparam int IDX_BITS = $clog2(ID_BITS + 1);
    localparam logic [IDLE_CNT_BITS-1:0] IDLE_LAST = IDLE_CNT_BITS'(IDLE_BITS - 1);
    localparam logic [RUN_BITS-1:0] RUN_FULL = RUN_BITS'(STUFF_LIMIT);
    localparam logic [IDX_BITS-1:0] ID_LAST = IDX_BITS'(ID_BITS - 1);

    typedef enum logic [1:0] {
        S_WAIT_IDLE,
        S_WAIT_SOF,
        S_COLLECT
    } monState_t;

    monState_t               state;
    logic [IDLE_CNT_BITS-1:0] idleCnt;
    logic [RUN_BITS-1:0]      runLen;
    logic                     runBit;
    logic [IDX_BITS-1:0]      idCnt;
    logic [ID_BITS-1:0]       idShift;
    logic [ID_BITS-1:0]       idNext;
    logic                     takeBit;

    // A bit after a full run is stuffing and carries no data
    assign takeBit = i_bit.strobe && (state == S_COLLECT) && (runLen != RUN_FULL);
    assign idNext = {idShift[ID_BITS-2:0], i_bit.value};

    // Identifier shifts in MSB first
    always_ff @(posedge clk) begin
        if (takeBit) begin
            idShift <= idNext;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state <= S_WAIT_IDLE;
            idleCnt <= '0;
            runLen <= '0;
            runBit <= 1'b1;
            idCnt <= '0;
            o_decision <= '0;
        end else begin
            o_decision.valid <= 1'b0;
            if (i_bit.strobe) begin
                case (state)
                    S_WAIT_IDLE: begin
                        if (!i_bit.value) begin
                            idleCnt <= '0;
                        end else if (idleCnt == IDLE_LAST) begin
                            idleCnt <= '0;
                            state <= S_WAIT_SOF;
                        end else begin
                            idleCnt <= idleCnt + 1'b1;
                        end
                    end
                    S_WAIT_SOF: begin
                        // SOF opens the first stuffing run
                        if (!i_bit.value) begin
                            runBit <= 1'b0;
                            runLen <= RUN_BITS'(1);
                            idCnt <= '0;
                            state <= S_COLLECT;
                        end
                    end
                    S_COLLECT: begin
                        if (!takeBit) begin
                            runBit <= i_bit.value;
                            runLen <= RUN_BITS'(1);
                        end else begin
                            if (i_bit.value == runBit) begin
                                runLen <= runLen + 1'b1;
                            end else begin
                                runBit <= i_bit.value;
                                runLen <= RUN_BITS'(1);
                            end
                            if (idCnt == ID_LAST) begin
                                o_decision.valid <= 1'b1;
                                o_decision.match <= (idNext == i_canId);
                                idleCnt <= '0;
                                state <= S_WAIT_IDLE;
                            end else begin
                                idCnt <= idCnt + 1'b1;
                            end
                        end
                    end
                    default: state <= S_WAIT_IDLE;
                endcase
            end
        end
    end

    // Decisions only come out of the identifier field
    assert property (@(posedge clk) disable iff (!resetN)
        o_decision.valid |-> $past(state) == S_COLLECT);

endmodule

// ==== sigFetch.sv ====
module sigFetch
    import canDelay_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        resetN,
    input  idDecision_t i_decision,
    input  sigRegion_t  i_validRegion,
    input  sigRegion_t  i_invalidRegion,
    output wbReq_t      o_wbReq,
    input  wbRsp_t      i_wbRsp,
    output sigWord_t    o_head,
    output logic        o_wordAvail,
    output logic        o_primed,
    input  logic        i_pop,
    input  logic        i_playDone
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(FIFO_DEPTH - 1);
    localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(FIFO_DEPTH);

    typedef enum logic [1:0] {
        F_IDLE,
        F_FETCH,
        F_DRAIN
    } fetchState_t;

    fetchState_t          state;
    sigRegion_t           selRegion;
    logic [ADDR_BITS-1:0] addr;
    logic [ADDR_BITS-1:0] wordsLeft;
    logic                 reqActive;
    sigWord_t             fifoMem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]  wrPtr;
    logic [PTR_BITS-1:0]  rdPtr;
    logic [CNT_BITS-1:0]  count;
    logic                 fifoFull;
    logic                 push;
    logic                 startRead;

    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
    endfunction

    assign selRegion = i_decision.match ? i_validRegion : i_invalidRegion;
    assign fifoFull = (count == CNT_FULL);
    assign push = reqActive & i_wbRsp.ack;
    // cyc must have been low a cycle before a new read
    assign startRead = (state == F_FETCH) && !reqActive && !fifoFull;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state <= F_IDLE;
            addr <= '0;
            wordsLeft <= '0;
            reqActive <= 1'b0;
            o_primed <= 1'b0;
        end else if (i_playDone) begin
            state <= F_IDLE;
            reqActive <= 1'b0;
            o_primed <= 1'b0;
        end else begin
            if (state == F_IDLE) begin
                if (i_decision.valid && selRegion.numWords != '0) begin
                    addr <= selRegion.base;
                    wordsLeft <= selRegion.numWords;
                    state <= F_FETCH;
                end
            end else if (state == F_FETCH) begin
                if (startRead) begin
                    reqActive <= 1'b1;
                end
                if (push) begin
                    reqActive <= 1'b0;
                    addr <= addr + 1'b1;
                    wordsLeft <= wordsLeft - 1'b1;
                    if (wordsLeft == ADDR_BITS'(1)) begin
                        state <= F_DRAIN;
                    end
                end
            end
            // Enough buffered to play without gaps
            if (state != F_IDLE && (fifoFull || state == F_DRAIN)) begin
                o_primed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifoMem[wrPtr] <= '{last: (wordsLeft == ADDR_BITS'(1)), data: i_wbRsp.dat};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (i_pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !i_pop) begin
                count <= count + 1'b1;
            end else if (!push && i_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_head = fifoMem[rdPtr];
    assign o_wordAvail = (count != '0);
    assign o_wbReq = '{cyc: reqActive, stb: reqActive, we: 1'b0, adr: addr};

    // Reads start only with room in the FIFO
    assert property (@(posedge clk) disable iff (!resetN)
        $rose(o_wbReq.stb) |-> !fifoFull);

    // Address held until the slave acknowledges
    assert property (@(posedge clk) disable iff (!resetN)
        (o_wbReq.stb && !i_wbRsp.ack) |=> (o_wbReq.stb && $stable(o_wbReq.adr)));

endmodule

// ==== sigPlayback.sv ====
module sigPlayback
    import canDelay_pkg::*;
#(
    parameter int PLAYBACK_PERIOD = 4
) (
    input  logic     clk,
    input  logic     resetN,
    input  sigWord_t i_head,
    input  logic     i_wordAvail,
    input  logic     i_primed,
    output logic     o_pop,
    output logic     o_playDone,
    output logic     o_txBit,
    output logic     o_txEnable
);

    localparam int PER_BITS = (PLAYBACK_PERIOD > 1) ? $clog2(PLAYBACK_PERIOD) : 1;
    localparam int IDX_BITS = $clog2(WORD_BITS);
    localparam logic [PER_BITS-1:0] PER_LAST = PER_BITS'(PLAYBACK_PERIOD - 1);
    localparam logic [IDX_BITS-1:0] IDX_LAST = IDX_BITS'(WORD_BITS - 1);

    logic                 running;
    logic [PER_BITS-1:0]  periodCnt;
    logic [IDX_BITS-1:0]  bitIdx;
    logic [WORD_BITS-1:0] shiftReg;
    logic                 wordLast;
    logic                 bitEnd;
    logic                 wordEnd;
    logic                 startPlay;
    logic                 needPop;

    assign bitEnd = running && (periodCnt == PER_LAST);
    assign wordEnd = bitEnd && (bitIdx == IDX_LAST);
    assign startPlay = !running && i_primed && i_wordAvail;
    assign needPop = wordEnd && !wordLast;
    assign o_pop = startPlay || (needPop && i_wordAvail);

    // Current word, LSB goes out first
    always_ff @(posedge clk) begin
        if (o_pop) begin
            shiftReg <= i_head.data;
            wordLast <= i_head.last;
        end else if (bitEnd) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            running <= 1'b0;
            periodCnt <= '0;
            bitIdx <= '0;
            o_txBit <= 1'b0;
            o_txEnable <= 1'b0;
            o_playDone <= 1'b0;
        end else begin
            o_playDone <= 1'b0;
            if (o_pop) begin
                running <= 1'b1;
                periodCnt <= '0;
                bitIdx <= '0;
                o_txBit <= i_head.data[0];
                o_txEnable <= 1'b1;
            end else if (wordEnd && wordLast) begin
                // Enable drops together with the done pulse
                running <= 1'b0;
                o_txBit <= 1'b0;
                o_txEnable <= 1'b0;
                o_playDone <= 1'b1;
            end else if (bitEnd) begin
                periodCnt <= '0;
                bitIdx <= bitIdx + 1'b1;
                o_txBit <= shiftReg[1];
            end else if (running) begin
                periodCnt <= periodCnt + 1'b1;
            end
        end
    end

    // Fetch side keeps ahead of the shifter
    assert property (@(posedge clk) disable iff (!resetN)
        needPop |-> i_wordAvail);

endmodule

// ==== canDelayTop.sv ====
module canDelayTop
    import canDelay_pkg::*;
#(
    parameter int CLKS_PER_BIT = 20,
    parameter int PLAYBACK_PERIOD = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               resetN,
    input  logic               i_canRx,
    input  logic [ID_BITS-1:0] i_canId,
    input  sigRegion_t         i_validRegion,
    input  sigRegion_t         i_invalidRegion,
    output wbReq_t             o_wbReq,
    input  wbRsp_t             i_wbRsp,
    output logic               o_txBit,
    output logic               o_txEnable
);

    canBit_t     sampledBit;
    idDecision_t decision;
    sigWord_t    fifoHead;
    logic        wordAvail;
    logic        primed;
    logic        pop;
    logic        playDone;

    // Bit recovery from the receive line
    canSampler #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) canSampler_inst (
        .clk(clk),
        .resetN(resetN),
        .i_canRx(i_canRx),
        .o_bit(sampledBit)
    );

    frameMonitor frameMonitor_inst (
        .clk(clk),
        .resetN(resetN),
        .i_bit(sampledBit),
        .i_canId(i_canId),
        .o_decision(decision)
    );

    // Memory reads into the word FIFO
    sigFetch #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) sigFetch_inst (
        .clk(clk),
        .resetN(resetN),
        .i_decision(decision),
        .i_validRegion(i_validRegion),
        .i_invalidRegion(i_invalidRegion),
        .o_wbReq(o_wbReq),
        .i_wbRsp(i_wbRsp),
        .o_head(fifoHead),
        .o_wordAvail(wordAvail),
        .o_primed(primed),
        .i_pop(pop),
        .i_playDone(playDone)
    );

    sigPlayback #(
        .PLAYBACK_PERIOD(PLAYBACK_PERIOD)
    ) sigPlayback_inst (
        .clk(clk),
        .resetN(resetN),
        .i_head(fifoHead),
        .i_wordAvail(wordAvail),
        .i_primed(primed),
        .o_pop(pop),
        .o_playDone(playDone),
        .o_txBit(o_txBit),
        .o_txEnable(o_txEnable)
    );

endmodule

// ==== tbWbMem.sv ====
module tbWbMem
    import canDelay_pkg::*;
#(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] SEED = 32'h29eb_bee3
) (
    input  logic   clk,
    input  logic   resetN,
    input  wbReq_t i_wbReq,
    output wbRsp_t o_wbRsp
);

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    logic [WORD_BITS-1:0] mem [MEM_WORDS];
    integer               seed;
    int                   waited;
    int                   target;
    int                   a;

    // Fill pattern built from every address bit
    initial begin
        seed = SEED;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {8'(a) ^ 8'hc3, ~8'(a), 8'(a * 7), 8'(a) + 8'h5a};
        end
    end

    // Ack comes 1 to 4 cycles after stb and lasts one cycle
    always @(posedge clk) begin
        if (!resetN) begin
            o_wbRsp <= '0;
            waited <= 0;
        end else begin
            o_wbRsp.ack <= 1'b0;
            if (i_wbReq.cyc && i_wbReq.stb && !o_wbRsp.ack) begin
                if (waited == 0) begin
                    target = 1 + ($unsigned($random(seed)) % 4);
                end
                if (waited + 1 >= target) begin
                    o_wbRsp.ack <= 1'b1;
                    o_wbRsp.dat <= mem[i_wbReq.adr[IDX_BITS-1:0]];
                    waited <= 0;
                end else begin
                    waited <= waited + 1;
                end
            end
        end
    end

endmodule

// ==== tb_canDelay.sv ====
module tb_canDelay
    import canDelay_pkg::*;
();

    localparam int CLKS_PER_BIT = 20;
    localparam int PLAYBACK_PERIOD = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam sigRegion_t VALID_REGION = '{base: 16'h0010, numWords: 16'd6};
    localparam sigRegion_t INVALID_REGION = '{base: 16'h0083, numWords: 16'd4};

    // Run length budget in clock cycles
    localparam int NUM_FRAMES = 11;
    localparam int FRAME_BITS = 40;
    localparam int NUM_PLAYS = 9;
    localparam int QUIET_BITS = 50;
    localparam int PLAY_CYCLES = 6 * WORD_BITS * PLAYBACK_PERIOD + 100;
    localparam int RUN_CYCLES = (NUM_FRAMES * FRAME_BITS + QUIET_BITS) * CLKS_PER_BIT
                                + NUM_PLAYS * PLAY_CYCLES;
    localparam int TIME_LIMIT = (RUN_CYCLES + 2000) * CLK_PERIOD;

    logic               clk;
    logic               resetN;
    logic               canRx;
    logic [ID_BITS-1:0] canId;
    sigRegion_t         validRegion;
    sigRegion_t         invalidRegion;
    wbReq_t             wbReq;
    wbRsp_t             wbRsp;
    logic               txBit;
    logic               txEnable;

    sigRegion_t expectedRegions [$];
    logic       busExpected;
    int         expectedPlays;
    int         playsDone;
    int         errorCount;

    canDelayTop #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PLAYBACK_PERIOD(PLAYBACK_PERIOD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) canDelayTop_inst (
        .clk(clk),
        .resetN(resetN),
        .i_canRx(canRx),
        .i_canId(canId),
        .i_validRegion(validRegion),
        .i_invalidRegion(invalidRegion),
        .o_wbReq(wbReq),
        .i_wbRsp(wbRsp),
        .o_txBit(txBit),
        .o_txEnable(txEnable)
    );

    tbWbMem #(
        .SEED(32'h29eb_bee3)
    ) tbWbMem_inst (
        .clk(clk),
        .resetN(resetN),
        .i_wbReq(wbReq),
        .o_wbRsp(wbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stopOnError(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                  $time, name, got, exp));
        end
    endtask

    task automatic checkReq(input string name, input wbReq_t got, input wbReq_t exp);
        if (got !== exp) begin
            stopOnError($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                  $time, name, got, exp));
        end
    endtask

    // Bit n of a stored signal, words in address order and LSB first
    function automatic logic expectedBit(input sigRegion_t region, input int n);
        logic [WORD_BITS-1:0] word;
        word = tbWbMem_inst.mem[8'(region.base + n / WORD_BITS)];
        return word[n % WORD_BITS];
    endfunction

    task automatic driveBit(input logic b);
        @(posedge clk);
        #1;
        canRx = b;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic waitBits(input int n);
        repeat (n * CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic setId(input logic [ID_BITS-1:0] id);
        @(posedge clk);
        #1;
        canId = id;
    endtask

    // Idle, SOF, stuffed identifier, then recessive tail
    task automatic sendFrame(input logic [ID_BITS-1:0] id, input int idleBits,
                             input int tailBits);
        int   i;
        logic runVal;
        int   runLen;
        logic b;
        for (i = 0; i < idleBits; i++) begin
            driveBit(1'b1);
        end
        driveBit(1'b0);
        runVal = 1'b0;
        runLen = 1;
        for (i = ID_BITS - 1; i >= 0; i--) begin
            b = id[i];
            driveBit(b);
            if (b == runVal) begin
                runLen++;
            end else begin
                runVal = b;
                runLen = 1;
            end
            // Stuff bits count toward the next run
            if (runLen == STUFF_LIMIT) begin
                runVal = ~runVal;
                runLen = 1;
                driveBit(runVal);
            end
        end
        for (i = 0; i < tailBits; i++) begin
            driveBit(1'b1);
        end
    endtask

    // Region follows from the identifier compare
    task automatic playFrame(input logic [ID_BITS-1:0] cfgId,
                             input logic [ID_BITS-1:0] frameId);
        setId(cfgId);
        busExpected = 1'b1;
        expectedRegions.push_back((frameId == cfgId) ? VALID_REGION : INVALID_REGION);
        expectedPlays++;
        sendFrame(frameId, 12, 11);
        wait (playsDone == expectedPlays);
    endtask

    initial begin : stimulus
        resetN = 1'b0;
        canRx = 1'b1;
        canId = '0;
        validRegion = VALID_REGION;
        invalidRegion = INVALID_REGION;
        busExpected = 1'b0;
        expectedPlays = 0;
        playsDone = 0;
        errorCount = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetN = 1'b1;

        // No idle before SOF, so nothing may play
        setId(11'h123);
        sendFrame(11'h123, 0, 3);
        waitBits(30);

        playFrame(11'h123, 11'h123);
        playFrame(11'h123, 11'h124);

        // Identifiers that force stuffing
        playFrame(11'h000, 11'h000);
        playFrame(11'h000, 11'h001);
        playFrame(11'h7FF, 11'h7FF);
        playFrame(11'h7FF, 11'h7FE);
        playFrame(11'h7C1, 11'h7C1);
        playFrame(11'h7C1, 11'h7C0);

        // Second frame lands while the first signal still plays
        setId(11'h2A5);
        busExpected = 1'b1;
        expectedRegions.push_back(VALID_REGION);
        expectedPlays++;
        sendFrame(11'h2A5, 12, 11);
        sendFrame(11'h0F0, 0, 11);
        wait (playsDone == expectedPlays);
        waitBits(20);

        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Samples the middle of every playback bit
    initial begin : comparePlayback
        sigRegion_t region;
        int         numBits;
        int         k;
        forever begin
            @(posedge txEnable);
            if (expectedRegions.size() == 0) begin
                stopOnError("Playback started although no frame should have triggered it");
            end
            region = expectedRegions.pop_front();
            numBits = region.numWords * WORD_BITS;
            repeat (PLAYBACK_PERIOD / 2) @(negedge clk);
            for (k = 0; k < numBits; k++) begin
                if (k != 0) begin
                    repeat (PLAYBACK_PERIOD) @(negedge clk);
                end
                checkBit("o_txEnable", txEnable, 1'b1);
                checkBit("o_txBit", txBit, expectedBit(region, k));
            end
            repeat (PLAYBACK_PERIOD / 2) @(negedge clk);
            checkBit("o_txEnable", txEnable, 1'b1);
            @(negedge clk);
            checkBit("o_txEnable", txEnable, 1'b0);
            busExpected = 1'b0;
            playsDone++;
        end
    end

    // Bus and transmitter stay quiet outside an expected playback
    initial begin : watchQuiet
        forever begin
            @(negedge clk);
            if (resetN && !busExpected) begin
                checkBit("o_wbReq.cyc", wbReq.cyc, 1'b0);
                checkBit("o_wbReq.stb", wbReq.stb, 1'b0);
                checkBit("o_txEnable", txEnable, 1'b0);
            end
        end
    end

    // Request held unchanged until ack
    initial begin : watchAddress
        wbReq_t held;
        logic   waiting;
        waiting = 1'b0;
        forever begin
            @(negedge clk);
            if (waiting) begin
                checkReq("o_wbReq", wbReq, held);
            end
            if (resetN && wbReq.stb) begin
                checkBit("o_wbReq.we", wbReq.we, 1'b0);
            end
            waiting = resetN && wbReq.stb && !wbRsp.ack;
            held = wbReq;
        end
    end

    initial begin : watchdog
        #(TIME_LIMIT);
        stopOnError("Timeout: the run did not finish within the expected time");
    end

endmodule

// ==== src.f ====
canDelay_pkg.sv
canSampler.sv
frameMonitor.sv
sigFetch.sv
sigPlayback.sv
canDelayTop.sv
tbWbMem.sv
tb_canDelay.sv

// ==== Bender.yml ====
package:
  name: canDelay

sources:
  - files:
      - canDelay_pkg.sv
      - canSampler.sv
      - frameMonitor.sv
      - sigFetch.sv
      - sigPlayback.sv
      - canDelayTop.sv
  - target: test
    files:
      - tbWbMem.sv
      - tb_canDelay.sv
